// File: verilog/vdp_cmd_pkg.sv
// Command engine definitions
// Command and logical operation codes, command register struct
`default_nettype none

package vdp_cmd_pkg;

  localparam int reg_num_w = 4;   // Host register index
  localparam int coord_w   = 10;

  typedef logic [coord_w-1:0] coord_t;

  // Codes kept from the R46 command field
  typedef enum logic [3:0] {
    cmd_stop  = 4'd0,
    cmd_point = 4'd4,
    cmd_pset  = 4'd5,
    cmd_lmmv  = 4'd8,
    cmd_lmmm  = 4'd9,
    cmd_hmmv  = 4'd12,
    cmd_hmmm  = 4'd13
  } cmd_code_e;

  typedef enum logic [2:0] {
    op_imp = 3'd0,
    op_and = 3'd1,
    op_or  = 3'd2,
    op_eor = 3'd3,
    op_not = 3'd4
  } logop_e;

  typedef struct packed {
    coord_t    sx;
    coord_t    dx;
    coord_t    nx;
    coord_t    sy;
    coord_t    dy;
    coord_t    ny;
    logic [7:0] clr;
    logic      mm;           // Unused by the kept commands
    logic      eq;
    logic      dix;          // Step left
    logic      diy;          // Step up
    cmd_code_e cmd;
    logic      transparent;
    logop_e    logop;
  } cmd_reg_t;

  // High-speed commands move whole bytes
  function automatic logic is_byte_cmd(input cmd_code_e c);
    return c == cmd_hmmv || c == cmd_hmmm;
  endfunction

endpackage

`default_nettype wire

// File: verilog/vdp_vram_pkg.sv
// VRAM side definitions
// Screen modes, address width, read and write request payloads
`default_nettype none

package vdp_vram_pkg;

  localparam int vram_addr_w = 17;   // 128 KiB

  typedef enum logic [1:0] {
    mode_g4 = 2'd0,
    mode_g5 = 2'd1,
    mode_g6 = 2'd2,
    mode_g7 = 2'd3
  } gfx_mode_e;

  typedef struct packed {
    logic      cmd_enable;   // Any bitmap mode active
    gfx_mode_e mode;
  } gfx_mode_t;

  typedef struct packed {
    logic [vram_addr_w-1:0] addr;
  } vram_rd_t;

  typedef struct packed {
    logic [vram_addr_w-1:0] addr;
    logic [7:0]             data;
  } vram_wr_t;

  // Log2 of pixels per byte
  function automatic logic [1:0] pix_shift(input gfx_mode_e m);
    case (m)
      mode_g5: return 2'd2;
      mode_g7: return 2'd0;
      default: return 2'd1;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: verilog/vdp_cmd_regs.sv
// Command register file R32 to R46
// Toggle handshake for host writes, command start pulse
`timescale 1ns/100ps
`default_nettype none

module vdp_cmd_regs (
  input  wire                                 clk,
  input  wire                                 reset,
  input  wire vdp_vram_pkg::gfx_mode_t        mode,
  input  wire                                 reg_wr_req,
  input  wire [vdp_cmd_pkg::reg_num_w-1:0]    reg_num,
  input  wire [7:0]                           reg_data,
  input  wire                                 clr_load,
  input  wire [7:0]                           clr_value,
  output logic                                reg_wr_ack,
  output vdp_cmd_pkg::cmd_reg_t               regs,
  output logic                                cmd_start,
  output logic                                reg_stall
);

  // Pending write holds the engine
  assign reg_stall = reg_wr_req != reg_wr_ack;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      reg_wr_ack <= 1'b0;
      cmd_start  <= 1'b0;
      regs       <= '0;
    end else begin
      cmd_start <= 1'b0;
      if (reg_wr_req != reg_wr_ack) begin
        reg_wr_ack <= ~reg_wr_ack;
        case (reg_num)
          4'd0:  regs.sx[7:0] <= reg_data;
          4'd1:  regs.sx[9:8] <= reg_data[1:0];
          4'd2:  regs.sy[7:0] <= reg_data;
          4'd3:  regs.sy[9:8] <= reg_data[1:0];
          4'd4:  regs.dx[7:0] <= reg_data;
          4'd5:  regs.dx[9:8] <= reg_data[1:0];
          4'd6:  regs.dy[7:0] <= reg_data;
          4'd7:  regs.dy[9:8] <= reg_data[1:0];
          4'd8:  regs.nx[7:0] <= reg_data;
          4'd9:  regs.nx[9:8] <= reg_data[1:0];
          4'd10: regs.ny[7:0] <= reg_data;
          4'd11: regs.ny[9:8] <= reg_data[1:0];
          4'd12: regs.clr     <= reg_data;
          4'd13: begin
            regs.mm  <= reg_data[0];
            regs.eq  <= reg_data[1];
            regs.dix <= reg_data[2];
            regs.diy <= reg_data[3];
          end
          4'd14: begin
            regs.cmd         <= vdp_cmd_pkg::cmd_code_e'(reg_data[7:4]);
            regs.transparent <= reg_data[3];
            regs.logop       <= vdp_cmd_pkg::logop_e'(reg_data[2:0]);
            cmd_start        <= mode.cmd_enable;   // Aborts a running command
          end
          default: ;
        endcase
      end else if (clr_load) begin
        regs.clr <= clr_value;   // POINT result
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/vdp_vram_port.sv
// Toggle request port to VRAM
// Holds one request payload until the next start
`timescale 1ns/100ps
`default_nettype none

module vdp_vram_port #(
  parameter type payload_t = logic [7:0]
) (
  input  wire      clk,
  input  wire      reset,
  input  wire      start,
  input  wire      payload_t payload_in,
  input  wire      ack,
  output logic     req,
  output payload_t payload,
  output logic     busy
);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      req <= 1'b0;
    end else if (start) begin
      req <= ~req;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      payload <= payload_in;   // Stable until acknowledged
    end
  end

  // Outstanding until the memory side echoes the toggle
  assign busy = req != ack;

endmodule

`default_nettype wire

// File: verilog/vdp_pixel_unit.sv
// Pixel datapath for the command engine
// Pixel extraction, logical operation, merge into the VRAM byte
`timescale 1ns/100ps
`default_nettype none

module vdp_pixel_unit (
  input  wire vdp_vram_pkg::gfx_mode_e mode,
  input  wire                          byte_cmd,
  input  wire vdp_cmd_pkg::logop_e     logop,
  input  wire                          transparent,
  input  wire [7:0]                    rd_byte,
  input  wire [1:0]                    pix_pos,
  input  wire [7:0]                    src_colour,
  output logic [7:0]                   rd_point,
  output logic [7:0]                   wr_byte
);

  logic [7:0] mask;   // Pixel depth
  logic [2:0] sh;     // Bit offset of the addressed pixel
  logic [7:0] pix;
  logic [7:0] src;
  logic [7:0] res;
  logic [7:0] merged;

  // Leftmost pixel sits in the high bits
  always_comb begin
    case (mode)
      vdp_vram_pkg::mode_g5: begin
        mask = 8'h03;
        sh   = 3'd6 - {pix_pos, 1'b0};
      end
      vdp_vram_pkg::mode_g7: begin
        mask = 8'hff;
        sh   = 3'd0;
      end
      default: begin
        mask = 8'h0f;
        sh   = pix_pos[0] ? 3'd0 : 3'd4;
      end
    endcase
  end

  assign pix = (rd_byte >> sh) & mask;
  assign src = src_colour & mask;

  always_comb begin
    case (logop)
      vdp_cmd_pkg::op_imp: res = src;
      vdp_cmd_pkg::op_and: res = src & pix;
      vdp_cmd_pkg::op_or:  res = src | pix;
      vdp_cmd_pkg::op_eor: res = src ^ pix;
      vdp_cmd_pkg::op_not: res = ~src & mask;
      default:             res = pix;   // Undefined codes keep the destination
    endcase
    if (transparent && src == 8'd0) begin
      res = pix;
    end
  end

  // Neighbouring pixels untouched
  assign merged = (rd_byte & ~(mask << sh)) | ((res & mask) << sh);

  assign rd_point = byte_cmd ? rd_byte : pix;
  assign wr_byte  = byte_cmd ? src_colour : merged;

endmodule

`default_nettype wire

// File: verilog/vdp_cmd_engine.sv
// Block command FSM for HMMV, HMMM, LMMV, LMMM, PSET and POINT
// Loop counters, right-edge clipping, pixel to VRAM address mapping
`timescale 1ns/100ps
`default_nettype none

module vdp_cmd_engine (
  input  wire                          clk,
  input  wire                          reset,
  input  wire vdp_vram_pkg::gfx_mode_t mode,
  input  wire vdp_cmd_pkg::cmd_reg_t   regs,
  input  wire                          cmd_start,
  input  wire                          reg_stall,
  input  wire                          rd_busy,
  input  wire                          wr_busy,
  input  wire [7:0]                    rd_point,
  input  wire [7:0]                    wr_byte,
  output logic                         rd_start,
  output vdp_vram_pkg::vram_rd_t       rd_payload,
  output logic                         wr_start,
  output vdp_vram_pkg::vram_wr_t       wr_payload,
  output logic [1:0]                   pix_pos,
  output logic [7:0]                   src_colour,
  output logic                         clr_load,
  output logic [7:0]                   clr_value,
  output logic                         ce
);

  typedef enum logic [2:0] {
    st_idle,
    st_chk_loop,
    st_rd_src,
    st_wait_src,
    st_rd_dst,
    st_wait_dst,
    st_wr,
    st_wait_wr
  } state_e;

  state_e              state;
  logic                init;         // First pass through the loop check
  vdp_cmd_pkg::coord_t sx_w, dx_w, sy_w, dy_w, ny_w, nx_w;
  vdp_cmd_pkg::coord_t step, x_step, y_step, nx_load;
  logic [7:0]          src_q;        // LMMM source pixel
  logic [7:0]          wr_q;         // Byte for the next write
  logic [1:0]          shift;
  logic                byte_cmd, copy_cmd, wide, row_end, ny_end, run;

  function automatic logic past_edge(input vdp_cmd_pkg::coord_t x, input logic wide_scr);
    return wide_scr ? x[9] : x[8];
  endfunction

  function automatic logic [vdp_vram_pkg::vram_addr_w-1:0] pix_addr(
    input vdp_vram_pkg::gfx_mode_e m,
    input vdp_cmd_pkg::coord_t     x,
    input vdp_cmd_pkg::coord_t     y
  );
    case (m)
      vdp_vram_pkg::mode_g4: return {y[9:0], x[7:1]};
      vdp_vram_pkg::mode_g5: return {y[9:0], x[8:2]};
      vdp_vram_pkg::mode_g6: return {y[8:0], x[8:1]};
      default:               return {y[8:0], x[7:0]};
    endcase
  endfunction

  assign byte_cmd = vdp_cmd_pkg::is_byte_cmd(regs.cmd);
  assign copy_cmd = regs.cmd inside {vdp_cmd_pkg::cmd_hmmm, vdp_cmd_pkg::cmd_lmmm};
  assign wide     = mode.mode inside {vdp_vram_pkg::mode_g5, vdp_vram_pkg::mode_g6};
  assign shift    = byte_cmd ? vdp_vram_pkg::pix_shift(mode.mode) : 2'd0;

  assign step    = vdp_cmd_pkg::coord_t'(1) << shift;   // Whole bytes for HMMx
  assign x_step  = regs.dix ? vdp_cmd_pkg::coord_t'(0) - step : step;
  assign y_step  = regs.diy ? '1 : vdp_cmd_pkg::coord_t'(1);
  assign nx_load = regs.nx >> shift;

  assign row_end = nx_w == '0 || past_edge(dx_w, wide) || (copy_cmd && past_edge(sx_w, wide));
  assign ny_end  = ny_w == vdp_cmd_pkg::coord_t'(1) ||
                   (regs.diy && (dy_w == '0 || (copy_cmd && sy_w == '0)));

  // FSM may advance this cycle
  assign run = !reg_stall && !cmd_start;

  assign rd_start   = run && !rd_busy && (state == st_rd_src || state == st_rd_dst);
  assign wr_start   = run && !wr_busy && state == st_wr;
  assign rd_payload = '{addr: (state == st_rd_src) ? pix_addr(mode.mode, sx_w, sy_w)
                                                   : pix_addr(mode.mode, dx_w, dy_w)};
  assign wr_payload = '{addr: pix_addr(mode.mode, dx_w, dy_w), data: wr_q};

  assign pix_pos    = (state == st_wait_src) ? sx_w[1:0] : dx_w[1:0];
  assign src_colour = (regs.cmd == vdp_cmd_pkg::cmd_lmmm) ? src_q : regs.clr;
  assign clr_load   = run && state == st_wait_src && !rd_busy &&
                      regs.cmd == vdp_cmd_pkg::cmd_point;
  assign clr_value  = rd_point;

  always_ff @(posedge clk) begin
    if (run) begin
      if (state == st_chk_loop) begin
        wr_q <= regs.clr;        // HMMV fill byte
      end
      if (state == st_wait_src && !rd_busy) begin
        src_q <= rd_point;
        wr_q  <= rd_point;       // HMMM copies the byte as read
      end
      if (state == st_wait_dst && !rd_busy) begin
        wr_q <= wr_byte;
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= st_idle;
      init  <= 1'b0;
      ce    <= 1'b0;
      sx_w  <= '0;
      dx_w  <= '0;
      sy_w  <= '0;
      dy_w  <= '0;
      ny_w  <= '0;
      nx_w  <= '0;
    end else if (cmd_start) begin
      sx_w  <= regs.sx;
      dx_w  <= regs.dx;
      sy_w  <= regs.sy;
      dy_w  <= regs.dy;
      ny_w  <= regs.ny;
      nx_w  <= nx_load;
      init  <= 1'b1;
      ce    <= 1'b1;
      state <= st_chk_loop;
    end else if (!reg_stall) begin
      case (state)
        st_chk_loop: begin
          init <= 1'b0;
          if (!init && row_end && ny_end) begin
            state <= st_idle;
            ce    <= 1'b0;
          end else begin
            case (regs.cmd)
              vdp_cmd_pkg::cmd_hmmv:  state <= st_wr;
              vdp_cmd_pkg::cmd_hmmm,
              vdp_cmd_pkg::cmd_lmmm,
              vdp_cmd_pkg::cmd_point: state <= st_rd_src;
              vdp_cmd_pkg::cmd_lmmv,
              vdp_cmd_pkg::cmd_pset:  state <= st_rd_dst;
              default: begin          // STOP and unknown codes
                state <= st_idle;
                ce    <= 1'b0;
              end
            endcase
          end
          if (!init && row_end) begin   // Next row
            nx_w <= nx_load;
            sx_w <= regs.sx;
            dx_w <= regs.dx;
            ny_w <= ny_w - vdp_cmd_pkg::coord_t'(1);
            dy_w <= dy_w + y_step;
            if (copy_cmd) begin
              sy_w <= sy_w + y_step;
            end
          end
        end
        st_rd_src: if (rd_start) state <= st_wait_src;
        st_wait_src: begin
          if (!rd_busy) begin
            sx_w <= sx_w + x_step;
            case (regs.cmd)
              vdp_cmd_pkg::cmd_point: begin
                state <= st_idle;
                ce    <= 1'b0;
              end
              vdp_cmd_pkg::cmd_lmmm: state <= st_rd_dst;
              default:               state <= st_wr;
            endcase
          end
        end
        st_rd_dst:   if (rd_start) state <= st_wait_dst;
        st_wait_dst: if (!rd_busy) state <= st_wr;
        st_wr:       if (wr_start) state <= st_wait_wr;
        st_wait_wr: begin
          if (!wr_busy) begin
            if (regs.cmd == vdp_cmd_pkg::cmd_pset) begin
              state <= st_idle;
              ce    <= 1'b0;
            end else begin
              dx_w  <= dx_w + x_step;
              nx_w  <= nx_w - vdp_cmd_pkg::coord_t'(1);
              state <= st_chk_loop;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/vdp_command.sv
// VDP block command engine top
// Register file, FSM, pixel datapath and the two VRAM request ports
`timescale 1ns/100ps
`default_nettype none

module vdp_command (
  input  wire                               clk,
  input  wire                               reset,
  input  wire vdp_vram_pkg::gfx_mode_t      mode,
  input  wire                               reg_wr_req,
  input  wire [vdp_cmd_pkg::reg_num_w-1:0]  reg_num,
  input  wire [7:0]                         reg_data,
  input  wire                               vram_rd_ack,
  input  wire [7:0]                         vram_rd_data,
  input  wire                               vram_wr_ack,
  output logic                              reg_wr_ack,
  output logic                              vram_rd_req,
  output vdp_vram_pkg::vram_rd_t            vram_rd,
  output logic                              vram_wr_req,
  output vdp_vram_pkg::vram_wr_t            vram_wr,
  output logic [7:0]                        clr,
  output logic                              ce
);

  vdp_cmd_pkg::cmd_reg_t  regs;
  vdp_vram_pkg::vram_rd_t rd_payload;
  vdp_vram_pkg::vram_wr_t wr_payload;
  logic                   cmd_start, reg_stall, clr_load;
  logic                   rd_start, wr_start, rd_busy, wr_busy;
  logic [1:0]             pix_pos;
  logic [7:0]             clr_value, src_colour, rd_point, wr_byte;

  assign clr = regs.clr;   // Host-visible colour register

  vdp_cmd_regs u_regs (
    .clk,
    .reset,
    .mode,
    .reg_wr_req,
    .reg_num,
    .reg_data,
    .clr_load,
    .clr_value,
    .reg_wr_ack,
    .regs,
    .cmd_start,
    .reg_stall
  );

  vdp_cmd_engine u_engine (
    .clk,
    .reset,
    .mode,
    .regs,
    .cmd_start,
    .reg_stall,
    .rd_busy,
    .wr_busy,
    .rd_point,
    .wr_byte,
    .rd_start,
    .rd_payload,
    .wr_start,
    .wr_payload,
    .pix_pos,
    .src_colour,
    .clr_load,
    .clr_value,
    .ce
  );

  vdp_pixel_unit u_pixel (
    .mode        (mode.mode),
    .byte_cmd    (vdp_cmd_pkg::is_byte_cmd(regs.cmd)),
    .logop       (regs.logop),
    .transparent (regs.transparent),
    .rd_byte     (vram_rd_data),
    .pix_pos,
    .src_colour,
    .rd_point,
    .wr_byte
  );

  vdp_vram_port #(.payload_t(vdp_vram_pkg::vram_rd_t)) u_rd_port (
    .clk,
    .reset,
    .start      (rd_start),
    .payload_in (rd_payload),
    .ack        (vram_rd_ack),
    .req        (vram_rd_req),
    .payload    (vram_rd),
    .busy       (rd_busy)
  );

  vdp_vram_port #(.payload_t(vdp_vram_pkg::vram_wr_t)) u_wr_port (
    .clk,
    .reset,
    .start      (wr_start),
    .payload_in (wr_payload),
    .ack        (vram_wr_ack),
    .req        (vram_wr_req),
    .payload    (vram_wr),
    .busy       (wr_busy)
  );

endmodule

`default_nettype wire

// File: verification/vdp_command_asserts.sv
// Assertions for the command engine
// One VRAM request in flight, ce quiet until the first command
`timescale 1ns/100ps
`default_nettype none

module vdp_command_asserts (
  input wire clk,
  input wire reset,
  input wire rd_start,
  input wire rd_busy,
  input wire wr_start,
  input wire wr_busy,
  input wire cmd_start,
  input wire ce
);

  logic started;   // A command was ever started

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      started <= 1'b0;
    end else if (cmd_start) begin
      started <= 1'b1;
    end
  end

  // Other port idle at start, own port outstanding afterwards
  assert property (@(posedge clk) disable iff (reset) rd_start |-> !wr_busy ##1 rd_busy)
    else $error("Read request overlapped a write or did not become outstanding");

  assert property (@(posedge clk) disable iff (reset) wr_start |-> !rd_busy ##1 wr_busy)
    else $error("Write request overlapped a read or did not become outstanding");

  assert property (@(posedge clk) disable iff (reset) !started |-> !ce)
    else $error("ce high before any command start");

endmodule

bind vdp_cmd_engine vdp_command_asserts u_asserts (
  .clk       (clk),
  .reset     (reset),
  .rd_start  (rd_start),
  .rd_busy   (rd_busy),
  .wr_start  (wr_start),
  .wr_busy   (wr_busy),
  .cmd_start (cmd_start),
  .ce        (ce)
);

`default_nettype wire

// File: verification/vdp_command_tb.sv
// Testbench for the VDP block command engine
// VRAM model with random ack delay, directed tests, check task, watchdog
`timescale 1ns/100ps
`default_nettype none

module vdp_command_tb;

  localparam int mem_size        = 1 << vdp_vram_pkg::vram_addr_w;
  localparam int watchdog_cycles = 20000;

  logic                    clk;
  logic                    reset;
  vdp_vram_pkg::gfx_mode_t mode;
  logic                    reg_wr_req;
  logic [3:0]              reg_num;
  logic [7:0]              reg_data;
  logic                    vram_rd_ack;
  logic [7:0]              vram_rd_data;
  logic                    vram_wr_ack;
  logic                    reg_wr_ack;
  logic                    vram_rd_req;
  vdp_vram_pkg::vram_rd_t  vram_rd;
  logic                    vram_wr_req;
  vdp_vram_pkg::vram_wr_t  vram_wr;
  logic [7:0]              clr;
  logic                    ce;

  logic [7:0] mem [mem_size];       // VRAM model
  logic [7:0] exp_mem [mem_size];   // Expected VRAM contents
  integer     seed      = 62;
  int         wr_starts = 0;
  int         wr_done   = 0;

  vdp_command dut (.*);

  always #10 clk = ~clk;

  // Read side answers after 1 to 4 cycles, data valid with the ack
  always begin
    @(posedge clk);
    if (!reset && vram_rd_req != vram_rd_ack) begin
      repeat ($random(seed) & 3) @(posedge clk);
      vram_rd_data <= mem[vram_rd.addr];
      vram_rd_ack  <= vram_rd_req;
    end
  end

  always begin
    @(posedge clk);
    if (!reset && vram_wr_req != vram_wr_ack) begin
      repeat ($random(seed) & 3) @(posedge clk);
      mem[vram_wr.addr] = vram_wr.data;
      wr_done++;
      vram_wr_ack <= vram_wr_req;
    end
  end

  always @(vram_wr_req) begin
    if (!reset) begin
      wr_starts++;   // Every toggle is one started write
    end
  end

  task automatic stop_with_failure();
    $display("Simulation failed");
    $fatal(1, "Stopped at the first failure");
  endtask

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0d ns: %s: got %0h, expected %0h", $time, what, actual, expected);
      stop_with_failure();
    end
  endtask

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, a test never finished", watchdog_cycles);
    stop_with_failure();
  end

  function automatic int ppb(input vdp_vram_pkg::gfx_mode_e m);
    case (m)
      vdp_vram_pkg::mode_g5: return 4;
      vdp_vram_pkg::mode_g7: return 1;
      default:               return 2;
    endcase
  endfunction

  function automatic int byte_addr(input vdp_vram_pkg::gfx_mode_e m, input int x, input int y);
    case (m)
      vdp_vram_pkg::mode_g4: return y * 128 + x / 2;
      vdp_vram_pkg::mode_g5: return y * 128 + x / 4;
      vdp_vram_pkg::mode_g6: return y * 256 + x / 2;
      default:               return y * 256 + x;
    endcase
  endfunction

  // Leftmost pixel in the top bits
  function automatic int bit_offset(input vdp_vram_pkg::gfx_mode_e m, input int x);
    int bits;
    bits = 8 / ppb(m);
    return 8 - bits * ((x % ppb(m)) + 1);
  endfunction

  function automatic logic [7:0] depth_mask(input vdp_vram_pkg::gfx_mode_e m);
    return 8'((1 << (8 / ppb(m))) - 1);
  endfunction

  function automatic logic [7:0] exp_pixel(input vdp_vram_pkg::gfx_mode_e m,
                                           input int x, input int y);
    return (exp_mem[byte_addr(m, x, y)] >> bit_offset(m, x)) & depth_mask(m);
  endfunction

  task automatic set_exp_pixel(input vdp_vram_pkg::gfx_mode_e m, input int x, input int y,
                               input logic [7:0] value);
    int         a;
    logic [7:0] msk;
    a   = byte_addr(m, x, y);
    msk = depth_mask(m) << bit_offset(m, x);
    exp_mem[a] = (exp_mem[a] & ~msk) | (((value & depth_mask(m)) << bit_offset(m, x)) & msk);
  endtask

  function automatic logic [7:0] fill_pattern(input int a);
    logic [16:0] b;
    b = a[16:0];
    return b[7:0] ^ b[15:8] ^ {b[16], 7'h35};
  endfunction

  task automatic load_pattern();
    for (int i = 0; i < mem_size; i++) begin
      mem[i]     = fill_pattern(i);
      exp_mem[i] = mem[i];
    end
  endtask

  task automatic compare_mem();
    for (int i = 0; i < mem_size; i++) begin
      if (mem[i] !== exp_mem[i]) begin
        check(mem[i], exp_mem[i], $sformatf("VRAM byte at %0h", i));
      end
    end
  endtask

  task automatic set_mode(input vdp_vram_pkg::gfx_mode_e m);
    @(posedge clk);
    mode <= '{cmd_enable: 1'b1, mode: m};
  endtask

  // Ack must follow exactly one cycle after the request
  task automatic write_reg(input logic [3:0] num, input logic [7:0] data);
    @(posedge clk);
    reg_num    <= num;
    reg_data   <= data;
    reg_wr_req <= !reg_wr_req;
    #1 check(reg_wr_ack, !reg_wr_req, "reg_wr_ack toggled early");
    @(posedge clk);
    #1 check(reg_wr_ack, reg_wr_req, "reg_wr_ack one cycle after request");
  endtask

  task automatic setup_cmd(input int sx, input int sy, input int dx, input int dy,
                           input int nx, input int ny, input logic [7:0] colour,
                           input logic [7:0] arg);
    int vals [6];
    vals = '{sx, sy, dx, dy, nx, ny};
    for (int i = 0; i < 6; i++) begin
      write_reg(4'(2 * i), vals[i][7:0]);
      write_reg(4'(2 * i + 1), {6'd0, vals[i][9:8]});
    end
    write_reg(4'd12, colour);
    write_reg(4'd13, arg);
  endtask

  task automatic wait_ce(input logic level, input int limit);
    int n;
    n = 0;
    while (ce !== level) begin
      if (n >= limit) begin
        $display("ce did not go to %0d within %0d cycles", level, limit);
        stop_with_failure();
      end
      @(posedge clk);
      #1 n++;
    end
  endtask

  task automatic run_cmd(input logic [7:0] cmd_byte, input int limit);
    write_reg(4'd14, cmd_byte);
    wait_ce(1'b1, 4);
    wait_ce(1'b0, limit);
  endtask

  task automatic reset_and_reg_writes();
    check(ce, 1'b0, "ce after reset");
    check(vram_rd_req, 1'b0, "vram_rd_req after reset");
    check(vram_wr_req, 1'b0, "vram_wr_req after reset");
    write_reg(4'd0, 8'h12);
    write_reg(4'd12, 8'h5a);
    check(clr, 8'h5a, "clr readback");
  endtask

  task automatic hmmv_fill_g7();
    int n;
    set_mode(vdp_vram_pkg::mode_g7);
    load_pattern();
    setup_cmd(0, 0, 10, 20, 8, 4, 8'hc3, 8'h00);
    for (int y = 20; y < 24; y++) begin
      for (int x = 10; x < 18; x++) begin
        exp_mem[byte_addr(vdp_vram_pkg::mode_g7, x, y)] = 8'hc3;
      end
    end
    run_cmd(8'hc0, 2000);
    n = wr_done;
    repeat (20) @(posedge clk);
    check(wr_done, n, "writes after ce fell");
    compare_mem();
  endtask

  task automatic lmmv_eor_g4();
    set_mode(vdp_vram_pkg::mode_g4);
    load_pattern();
    setup_cmd(0, 0, 5, 3, 6, 2, 8'h09, 8'h00);
    for (int y = 3; y < 5; y++) begin
      for (int x = 5; x < 11; x++) begin
        set_exp_pixel(vdp_vram_pkg::mode_g4, x, y,
                      exp_pixel(vdp_vram_pkg::mode_g4, x, y) ^ 8'h09);
      end
    end
    run_cmd(8'h8b, 2000);   // LMMV, transparent, EOR
    compare_mem();
    setup_cmd(0, 0, 5, 3, 6, 2, 8'h00, 8'h00);
    run_cmd(8'h8b, 2000);   // Colour 0 is transparent
    compare_mem();
  endtask

  task automatic mirrored_copy_g5();
    logic [7:0] s;
    set_mode(vdp_vram_pkg::mode_g5);
    load_pattern();
    setup_cmd(40, 30, 100, 60, 16, 3, 8'h00, 8'h0c);   // dix and diy
    for (int r = 0; r < 3; r++) begin
      for (int k = 0; k < 4; k++) begin
        exp_mem[byte_addr(vdp_vram_pkg::mode_g5, 100 - 4 * k, 60 - r)] =
          exp_mem[byte_addr(vdp_vram_pkg::mode_g5, 40 - 4 * k, 30 - r)];
      end
    end
    run_cmd(8'hd0, 2000);
    compare_mem();
    setup_cmd(21, 40, 70, 80, 5, 2, 8'h00, 8'h0c);
    for (int r = 0; r < 2; r++) begin
      for (int k = 0; k < 5; k++) begin
        s = exp_pixel(vdp_vram_pkg::mode_g5, 21 - k, 40 - r);
        set_exp_pixel(vdp_vram_pkg::mode_g5, 70 - k, 80 - r,
                      exp_pixel(vdp_vram_pkg::mode_g5, 70 - k, 80 - r) & s);
      end
    end
    run_cmd(8'h91, 2000);   // LMMM with AND
    compare_mem();
  endtask

  task automatic pset_point_g6();
    set_mode(vdp_vram_pkg::mode_g6);
    load_pattern();
    setup_cmd(0, 0, 301, 77, 1, 1, 8'h3e, 8'h00);
    set_exp_pixel(vdp_vram_pkg::mode_g6, 301, 77, 8'h0e);
    run_cmd(8'h50, 200);
    compare_mem();
    setup_cmd(301, 77, 0, 0, 1, 1, 8'ha5, 8'h00);
    run_cmd(8'h40, 200);
    check(clr, 8'h0e, "POINT result in clr");
  endtask

  task automatic stop_aborts_fill();
    int n;
    int starts_at_ack;
    set_mode(vdp_vram_pkg::mode_g7);
    load_pattern();
    setup_cmd(0, 0, 0, 100, 256, 100, 8'h77, 8'h00);
    write_reg(4'd14, 8'hc0);
    n = 0;
    while (wr_done < 20) begin
      if (n >= 1000) begin
        $display("Large fill made no progress before the abort");
        stop_with_failure();
      end
      @(posedge clk);
      n++;
    end
    write_reg(4'd14, 8'h00);   // STOP
    starts_at_ack = wr_starts;
    wait_ce(1'b0, 20);
    repeat (20) @(posedge clk);
    check(wr_starts, starts_at_ack, "write started after STOP");
    check(wr_done, wr_starts, "write left outstanding after STOP");
  endtask

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    mode         = '{cmd_enable: 1'b1, mode: vdp_vram_pkg::mode_g7};
    reg_wr_req   = 1'b0;
    reg_num      = '0;
    reg_data     = '0;
    vram_rd_ack  = 1'b0;
    vram_rd_data = '0;
    vram_wr_ack  = 1'b0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    #1 reset_and_reg_writes();
    hmmv_fill_g7();
    lmmv_eor_g4();
    mirrored_copy_g5();
    pset_point_g6();
    stop_aborts_fill();
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vdp_command.f
verilog/vdp_cmd_pkg.sv
verilog/vdp_vram_pkg.sv
verilog/vdp_cmd_regs.sv
verilog/vdp_vram_port.sv
verilog/vdp_pixel_unit.sv
verilog/vdp_cmd_engine.sv
verilog/vdp_command.sv
verification/vdp_command_asserts.sv
verification/vdp_command_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the command engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f vdp_command.f --top-module vdp_command_tb -o vdp_command_sim \
  > build.log 2>&1 \
  && ./obj_dir/vdp_command_sim > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -qx "Simulation passed" sim.log \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL"; exit 1; }
